/* corr_pkg.sv */
package corr_pkg;

	// Defaults for the top level parameters
	localparam int NUM_INPUTS_DEF = 4;
	localparam int RESOLUTION_DEF = 16;

	// First byte of every packet
	localparam logic [7:0] PKT_HEADER = 8'hA5;

	typedef struct packed {
		logic enable;
		logic invert;
		logic edge_mode;
	} line_cfg_t;

	typedef enum logic [2:0] {
		START     = 3'd1,
		STOP      = 3'd2,
		CLEAR_CFG = 3'd3
	} ctl_op_e;

	// Config view of a command byte, is_cfg set
	typedef struct packed {
		logic       is_cfg;
		logic [2:0] line;
		logic       invert;
		logic       edge_mode;
		logic       enable;
		// Spare bit to fill the byte
		logic       rsvd;
	} cfg_cmd_t;

	// Control view of a command byte, is_cfg clear
	typedef struct packed {
		logic       is_cfg;
		ctl_op_e    op;
		logic [3:0] arg;
	} ctl_cmd_t;

	typedef union packed {
		cfg_cmd_t cfg;
		ctl_cmd_t ctl;
	} cmd_byte_u;

	function automatic int num_baselines(input int n);
		return (n * (n - 1)) / 2;
	endfunction

	// Pairs i<j, ordered by i then by j
	function automatic int baseline_index(input int i, input int j, input int n);
		return i * n - (i * (i + 1)) / 2 + (j - i - 1);
	endfunction

endpackage

/* line_conditioner.sv */
`timescale 1ns/100ps

module line_conditioner #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  corr_pkg::line_cfg_t   line_cfg [NUM_INPUTS],
	output logic [NUM_INPUTS-1:0] cond
);

	logic [NUM_INPUTS-1:0] inv_mask;
	logic [NUM_INPUTS-1:0] samp;
	logic [NUM_INPUTS-1:0] prev;

	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			inv_mask[i] = line_cfg[i].invert;
		end
	end

	// Conditioned sample before the edge and enable stage
	assign samp = line_in ^ inv_mask;

	always_ff @(posedge intclk) begin
		if (rst) begin
			prev <= '0;
			cond <= '0;
		end else begin
			prev <= samp;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				if (!line_cfg[i].enable) begin
					cond[i] <= 1'b0;
				end else if (line_cfg[i].edge_mode) begin
					// Rising edge only
					cond[i] <= samp[i] & ~prev[i];
				end else begin
					cond[i] <= samp[i];
				end
			end
		end
	end

endmodule

/* pulse_counter.sv */
`timescale 1ns/100ps

module pulse_counter #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF,
	parameter int RESOLUTION = corr_pkg::RESOLUTION_DEF
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] cond,
	input  logic                  integrating,
	input  logic                  clear_counts,
	output logic [RESOLUTION-1:0] counts [NUM_INPUTS]
);

	localparam logic [RESOLUTION-1:0] MAX_COUNT = '1;

	logic [NUM_INPUTS-1:0][RESOLUTION-1:0] cnt_q;

	always_ff @(posedge intclk) begin
		if (rst || clear_counts) begin
			cnt_q <= '0;
		end else if (integrating) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				// Hold at full scale
				if (cond[i] && cnt_q[i] != MAX_COUNT) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			counts[i] = cnt_q[i];
		end
	end

	// Counts are frozen between runs so the packet sees stable values
	count_frozen_idle: assert property (
		@(posedge intclk) disable iff (rst)
		!integrating && !clear_counts |=> $stable(cnt_q)
	) else $error("pulse_counter: count changed while idle");

endmodule

/* cross_correlator.sv */
`timescale 1ns/100ps

module cross_correlator #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF,
	parameter int RESOLUTION = corr_pkg::RESOLUTION_DEF
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] cond,
	input  logic                  integrating,
	input  logic                  clear_counts,
	output logic [RESOLUTION-1:0] xcounts [corr_pkg::num_baselines(NUM_INPUTS)]
);
	import corr_pkg::*;

	localparam int NUM_BL = num_baselines(NUM_INPUTS);
	localparam logic [RESOLUTION-1:0] MAX_COUNT = '1;

	logic [NUM_BL-1:0] hit;
	logic [NUM_BL-1:0][RESOLUTION-1:0] xcnt_q;

	// Zero lag coincidence of every line pair
	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_pair
			assign hit[baseline_index(i, j, NUM_INPUTS)] = cond[i] & cond[j];
		end
	end

	always_ff @(posedge intclk) begin
		if (rst || clear_counts) begin
			xcnt_q <= '0;
		end else if (integrating) begin
			for (int b = 0; b < NUM_BL; b++) begin
				if (hit[b] && xcnt_q[b] != MAX_COUNT) begin
					xcnt_q[b] <= xcnt_q[b] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int b = 0; b < NUM_BL; b++) begin
			xcounts[b] = xcnt_q[b];
		end
	end

endmodule

/* cmd_parser.sv */
`timescale 1ns/100ps

module cmd_parser #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF
) (
	input  logic                intclk,
	input  logic                rst,
	input  corr_pkg::cmd_byte_u rx_data,
	input  logic                rx_strobe,
	input  logic                tx_busy,
	output corr_pkg::line_cfg_t line_cfg [NUM_INPUTS],
	output logic                integrating,
	output logic                clear_counts,
	output logic                send
);
	import corr_pkg::*;

	// Enabled, not inverted, level mode
	localparam line_cfg_t CFG_RESET = '{enable: 1'b1, invert: 1'b0, edge_mode: 1'b0};

	always_ff @(posedge intclk) begin
		if (rst) begin
			integrating  <= 1'b0;
			clear_counts <= 1'b0;
			send         <= 1'b0;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				line_cfg[i] <= CFG_RESET;
			end
		end else begin
			clear_counts <= 1'b0;
			send         <= 1'b0;
			if (rx_strobe) begin
				if (rx_data.cfg.is_cfg) begin
					// Line config is locked while a run is active
					if (!integrating) begin
						for (int i = 0; i < NUM_INPUTS; i++) begin
							if (rx_data.cfg.line == 3'(i)) begin
								line_cfg[i] <= '{enable:    rx_data.cfg.enable,
								                 invert:    rx_data.cfg.invert,
								                 edge_mode: rx_data.cfg.edge_mode};
							end
						end
					end
				end else begin
					case (rx_data.ctl.op)
						START: begin
							// Wait for the previous packet to drain
							if (!tx_busy) begin
								integrating  <= 1'b1;
								clear_counts <= 1'b1;
							end
						end
						STOP: begin
							integrating <= 1'b0;
							send        <= 1'b1;
						end
						CLEAR_CFG: begin
							for (int i = 0; i < NUM_INPUTS; i++) begin
								line_cfg[i] <= CFG_RESET;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	start_stop_exclusive: assert property (
		@(posedge intclk) disable iff (rst)
		!(clear_counts && send)
	) else $error("cmd_parser: clear_counts and send together");

endmodule

/* packet_tx.sv */
`timescale 1ns/100ps

module packet_tx #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF,
	parameter int RESOLUTION = corr_pkg::RESOLUTION_DEF
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic                  send,
	input  logic [RESOLUTION-1:0] counts [NUM_INPUTS],
	input  logic [RESOLUTION-1:0] xcounts [corr_pkg::num_baselines(NUM_INPUTS)],
	output logic [7:0]            tx_data,
	output logic                  tx_strobe,
	output logic                  tx_busy
);
	import corr_pkg::*;

	localparam int NUM_BL = num_baselines(NUM_INPUTS);
	localparam int PAY_W = (NUM_INPUTS + NUM_BL) * RESOLUTION;
	localparam int PAY_BYTES = PAY_W / 8;
	localparam int IDX_W = $clog2(PAY_BYTES + 2);

	logic [PAY_W-1:0] payload;
	logic [PAY_W-1:0] snap;
	logic [IDX_W-1:0] idx;
	logic [7:0]       sum;
	logic [7:0]       next_byte;

	// First byte on the wire sits at the top of the vector
	always_comb begin
		payload = '0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			payload[PAY_W-1-i*RESOLUTION -: RESOLUTION] = counts[i];
		end
		for (int b = 0; b < NUM_BL; b++) begin
			payload[PAY_W-1-(NUM_INPUTS+b)*RESOLUTION -: RESOLUTION] = xcounts[b];
		end
	end

	assign next_byte = snap[PAY_W-1 -: 8];

	always_ff @(posedge intclk) begin
		if (rst) begin
			tx_busy   <= 1'b0;
			tx_strobe <= 1'b0;
			idx       <= '0;
		end else if (!tx_busy) begin
			tx_strobe <= 1'b0;
			if (send) begin
				// Snapshot so a new run cannot disturb this packet
				snap      <= payload;
				tx_busy   <= 1'b1;
				tx_strobe <= 1'b1;
				tx_data   <= PKT_HEADER;
				sum       <= PKT_HEADER;
				idx       <= '0;
			end
		end else if (idx < IDX_W'(PAY_BYTES)) begin
			tx_data <= next_byte;
			sum     <= sum + next_byte;
			snap    <= snap << 8;
			idx     <= idx + 1'b1;
		end else if (idx == IDX_W'(PAY_BYTES)) begin
			// Header plus all payload bytes, mod 256
			tx_data <= sum;
			idx     <= idx + 1'b1;
		end else begin
			tx_busy   <= 1'b0;
			tx_strobe <= 1'b0;
		end
	end

	strobe_in_busy: assert property (
		@(posedge intclk) disable iff (rst)
		tx_strobe |-> tx_busy
	) else $error("packet_tx: tx_strobe outside a packet");

endmodule

/* corr_top.sv */
`timescale 1ns/100ps

module corr_top #(
	parameter int NUM_INPUTS = corr_pkg::NUM_INPUTS_DEF,
	parameter int RESOLUTION = corr_pkg::RESOLUTION_DEF
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  logic [7:0]            rx_data,
	input  logic                  rx_strobe,
	output logic [7:0]            tx_data,
	output logic                  tx_strobe,
	output logic                  integrating,
	output logic                  tx_busy
);
	import corr_pkg::*;

	localparam int NUM_BL = num_baselines(NUM_INPUTS);

	line_cfg_t             line_cfg [NUM_INPUTS];
	logic [NUM_INPUTS-1:0] cond;
	logic                  clear_counts;
	logic                  send;
	logic [RESOLUTION-1:0] counts [NUM_INPUTS];
	logic [RESOLUTION-1:0] xcounts [NUM_BL];

	cmd_parser #(.NUM_INPUTS(NUM_INPUTS)) cmd_parser_inst (
		.intclk       (intclk),
		.rst          (rst),
		.rx_data      (rx_data),
		.rx_strobe    (rx_strobe),
		.tx_busy      (tx_busy),
		.line_cfg     (line_cfg),
		.integrating  (integrating),
		.clear_counts (clear_counts),
		.send         (send)
	);

	line_conditioner #(.NUM_INPUTS(NUM_INPUTS)) line_conditioner_inst (
		.intclk   (intclk),
		.rst      (rst),
		.line_in  (line_in),
		.line_cfg (line_cfg),
		.cond     (cond)
	);

	pulse_counter #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) pulse_counter_inst (
		.intclk       (intclk),
		.rst          (rst),
		.cond         (cond),
		.integrating  (integrating),
		.clear_counts (clear_counts),
		.counts       (counts)
	);

	cross_correlator #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) cross_correlator_inst (
		.intclk       (intclk),
		.rst          (rst),
		.cond         (cond),
		.integrating  (integrating),
		.clear_counts (clear_counts),
		.xcounts      (xcounts)
	);

	packet_tx #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) packet_tx_inst (
		.intclk    (intclk),
		.rst       (rst),
		.send      (send),
		.counts    (counts),
		.xcounts   (xcounts),
		.tx_data   (tx_data),
		.tx_strobe (tx_strobe),
		.tx_busy   (tx_busy)
	);

endmodule

/* tb_corr_top.sv */
`timescale 1ns/100ps

module tb_corr_top;
	import corr_pkg::*;

	localparam int NUM_INPUTS = 4;
	localparam int RESOLUTION = 16;
	localparam int NUM_BL = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int BYTES_PER = RESOLUTION / 8;
	localparam int PKT_LEN = 2 + (NUM_INPUTS + NUM_BL) * BYTES_PER;
	localparam int MAX_COUNT = (1 << RESOLUTION) - 1;
	localparam int NUM_ROWS = 8;

	typedef logic [RESOLUTION-1:0] count_t;

	typedef struct packed {
		line_cfg_t [NUM_INPUTS-1:0] cfg;
		logic                       use_clear;
		logic                       mid_cfg;
		logic                       rand_mode;
		logic [NUM_INPUTS-1:0]      pattern;
		int                         samples;
	} row_t;

	logic                  intclk = 1'b0;
	logic                  rst = 1'b1;
	logic [NUM_INPUTS-1:0] line_in = '0;
	logic [7:0]            rx_data = '0;
	logic                  rx_strobe = 1'b0;
	logic [7:0]            tx_data;
	logic                  tx_strobe;
	logic                  integrating;
	logic                  tx_busy;

	row_t       rows [NUM_ROWS];
	int         exp_line [NUM_INPUTS];
	int         exp_bl [NUM_BL];
	logic [7:0] pkt [$];
	int         seed = 59;
	int         fail_count = 0;
	int         cycles = 0;
	int         cycle_limit = 0;

	corr_top #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) corr_top_inst (
		.intclk      (intclk),
		.rst         (rst),
		.line_in     (line_in),
		.rx_data     (rx_data),
		.rx_strobe   (rx_strobe),
		.tx_data     (tx_data),
		.tx_strobe   (tx_strobe),
		.integrating (integrating),
		.tx_busy     (tx_busy)
	);

	always #5 intclk = ~intclk;

	always @(posedge intclk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("SOME TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

	task automatic abort_run(input string why);
		fail_count++;
		$display("%0t: %s", $time, why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			fail_count++;
			$display("[FAIL] %0t %s: got %02h, expected %02h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Byte mismatch");
		end
	endtask

	task automatic check_count(input count_t got, input count_t exp, input string what);
		if (got !== exp) begin
			fail_count++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Count mismatch");
		end
	endtask

	function automatic logic [7:0] cfg_byte(input int line, input line_cfg_t c);
		cmd_byte_u cb;
		cb = '0;
		cb.cfg.is_cfg = 1'b1;
		cb.cfg.line = 3'(line);
		cb.cfg.invert = c.invert;
		cb.cfg.edge_mode = c.edge_mode;
		cb.cfg.enable = c.enable;
		return cb;
	endfunction

	function automatic logic [7:0] ctl_byte(input ctl_op_e op);
		cmd_byte_u cb;
		cb.ctl.is_cfg = 1'b0;
		cb.ctl.op = op;
		cb.ctl.arg = '0;
		return cb;
	endfunction

	function automatic row_t make_row(input logic [3*NUM_INPUTS-1:0] cfg, input logic use_clear,
			input logic mid_cfg, input logic rand_mode, input logic [NUM_INPUTS-1:0] pattern,
			input int samples);
		row_t r;
		r.cfg = cfg;
		r.use_clear = use_clear;
		r.mid_cfg = mid_cfg;
		r.rand_mode = rand_mode;
		r.pattern = pattern;
		r.samples = samples;
		return r;
	endfunction

	task automatic drive_byte(input logic [7:0] b);
		@(negedge intclk);
		line_in = '0;
		rx_data = b;
		rx_strobe = 1'b1;
		@(negedge intclk);
		rx_strobe = 1'b0;
	endtask

	task automatic collect_packet(input int row);
		int waited;
		waited = 0;
		pkt.delete();
		while (!tx_busy) begin
			if (waited > 8)
				abort_run($sformatf("row %0d: no packet started after STOP", row));
			waited++;
			@(negedge intclk);
		end
		while (tx_busy) begin
			if (tx_strobe)
				pkt.push_back(tx_data);
			if (pkt.size() > PKT_LEN)
				abort_run($sformatf("row %0d: packet runs past %0d bytes", row, PKT_LEN));
			@(negedge intclk);
		end
		if (tx_strobe)
			abort_run($sformatf("row %0d: tx_strobe still high after tx_busy fell", row));
		if (integrating)
			abort_run($sformatf("row %0d: integrating still high after STOP", row));
	endtask

	task automatic check_packet(input int row);
		count_t     got;
		count_t     want;
		logic [7:0] sum;
		int         p;
		if (pkt.size() != PKT_LEN)
			abort_run($sformatf("row %0d: packet has %0d bytes, expected %0d",
				row, pkt.size(), PKT_LEN));
		check_byte(pkt[0], PKT_HEADER, $sformatf("row %0d header", row));
		sum = PKT_HEADER;
		p = 1;
		for (int i = 0; i < NUM_INPUTS + NUM_BL; i++) begin
			got = '0;
			if (i < NUM_INPUTS)
				want = count_t'(exp_line[i]);
			else
				want = count_t'(exp_bl[i-NUM_INPUTS]);
			// MSB first on the wire
			for (int k = 0; k < BYTES_PER; k++) begin
				got = (got << 8) | count_t'(pkt[p]);
				sum = sum + want[RESOLUTION-1-8*k -: 8];
				p++;
			end
			if (i < NUM_INPUTS)
				check_count(got, want, $sformatf("row %0d line %0d", row, i));
			else
				check_count(got, want, $sformatf("row %0d baseline %0d", row, i - NUM_INPUTS));
		end
		check_byte(pkt[PKT_LEN-1], sum, $sformatf("row %0d checksum", row));
	endtask

	task automatic run_row(input int row, input row_t r);
		line_cfg_t             mcfg [NUM_INPUTS];
		line_cfg_t             off;
		logic [NUM_INPUTS-1:0] s;
		logic [NUM_INPUTS-1:0] samp;
		logic [NUM_INPUTS-1:0] prev;
		logic [NUM_INPUTS-1:0] c;
		int                    b;
		off = '0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			exp_line[i] = 0;
			if (r.use_clear) begin
				mcfg[i] = '{enable: 1'b1, invert: 1'b0, edge_mode: 1'b0};
			end else begin
				mcfg[i] = r.cfg[i];
				drive_byte(cfg_byte(i, r.cfg[i]));
			end
			// Idle line is low, so the edge detector starts from the inverted idle level
			prev[i] = mcfg[i].invert;
		end
		for (int i = 0; i < NUM_BL; i++)
			exp_bl[i] = 0;
		if (r.use_clear)
			drive_byte(ctl_byte(CLEAR_CFG));
		drive_byte(ctl_byte(START));
		for (int k = 0; k < r.samples; k++) begin
			if (k > 0)
				@(negedge intclk);
			else if (!integrating)
				abort_run($sformatf("row %0d: integrating did not rise after START", row));
			s = r.rand_mode ? NUM_INPUTS'($random(seed)) : r.pattern;
			line_in = s;
			// Disables line 0 if it were accepted mid-run
			rx_data = cfg_byte(0, off);
			rx_strobe = r.mid_cfg && (k == r.samples / 2);
			for (int i = 0; i < NUM_INPUTS; i++) begin
				samp[i] = s[i] ^ mcfg[i].invert;
				if (!mcfg[i].enable)
					c[i] = 1'b0;
				else if (mcfg[i].edge_mode)
					c[i] = samp[i] & ~prev[i];
				else
					c[i] = samp[i];
				prev[i] = samp[i];
				if (c[i] && exp_line[i] < MAX_COUNT)
					exp_line[i]++;
			end
			b = 0;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				for (int j = i + 1; j < NUM_INPUTS; j++) begin
					if (c[i] && c[j] && exp_bl[b] < MAX_COUNT)
						exp_bl[b]++;
					b++;
				end
			end
		end
		drive_byte(ctl_byte(STOP));
		collect_packet(row);
		check_packet(row);
	endtask

	initial begin
		// cfg is {line3, line2, line1, line0}, each {enable, invert, edge_mode}
		rows[0] = make_row(12'h924, 1'b0, 1'b0, 1'b1, 4'h0, 200);
		rows[1] = make_row(12'hE2E, 1'b0, 1'b0, 1'b1, 4'h0, 300);
		rows[2] = make_row(12'hE2E, 1'b0, 1'b0, 1'b0, 4'b1010, 50);
		rows[3] = make_row(12'h924, 1'b0, 1'b1, 1'b1, 4'h0, 150);
		rows[4] = make_row(12'hB77, 1'b0, 1'b0, 1'b1, 4'h0, 120);
		rows[5] = make_row(12'h000, 1'b1, 1'b0, 1'b1, 4'h0, 120);
		rows[6] = make_row(12'h924, 1'b0, 1'b0, 1'b0, 4'b0111, 65600);
		rows[7] = make_row(12'h924, 1'b0, 1'b0, 1'b1, 4'h0, 100);
		cycle_limit = 20;
		for (int n = 0; n < NUM_ROWS; n++)
			cycle_limit += rows[n].samples + 2 * PKT_LEN + 40;
		repeat (5) @(negedge intclk);
		rst = 1'b0;
		for (int n = 0; n < NUM_ROWS; n++) begin
			run_row(n, rows[n]);
			$display("Row %0d checked, %0d samples", n, rows[n].samples);
		end
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "Checks failed");
		end
	end

endmodule

/* verilog.f */
corr_pkg.sv
line_conditioner.sv
pulse_counter.sv
cross_correlator.sv
cmd_parser.sv
packet_tx.sv
corr_top.sv
tb_corr_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_corr_top \
	-Mdir obj_dir -o sim_corr
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_corr > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
